//--- flist.f
+incdir+src
+incdir+tb
src/dec_pkg.sv
src/if_id_stage.sv
src/i_decoder.sv
src/m_decoder.sv
src/decoder.sv
src/id_ex_stage.sv
src/decode_top.sv
tb/decode_tb.sv

//--- Makefile
SIM     = verilator
FLAGS   = --binary --timing --assert --timescale 1ns/1ns -j 0
TOP     = decode_tb
FLIST   = flist.f
OBJ_DIR = obj_dir
BIN     = $(OBJ_DIR)/V$(TOP)
LOG     = sim.log
SRCS    = $(wildcard src/*.sv src/*.svh tb/*.sv tb/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb/decode_ref.svh
// Reference decoder and instruction encoders
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

//////////////////////////////
// Encoders
//////////////////////////////

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [6:0] opc);
  return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

// Stores, branches reuse it since only the immediate bits move
function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [6:0] opc);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [6:0] opc);
  return {imm, rd, opc};
endfunction

//////////////////////////////
// Expected decode
//////////////////////////////

// ALU column for funct3, alt picks the bit 30 variant
function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
  case (f3)
    3'd0:    return alt ? ALU_SUB : ALU_ADD;
    3'd1:    return ALU_SLL;
    3'd2:    return ALU_SLT;
    3'd3:    return ALU_SLTU;
    3'd4:    return ALU_XOR;
    3'd5:    return alt ? ALU_SRA : ALU_SRL;
    3'd6:    return ALU_OR;
    default: return ALU_AND;
  endcase
endfunction

function automatic decoder_ctrl_t ref_ctrl(input logic [31:0] ins, input logic ic,
                                           input logic fe);
  decoder_ctrl_t c;
  logic [2:0]    f3;
  logic [6:0]    f7;
  logic          ok;  // Encoding exists in RV32IM
  f3        = ins[14:12];
  f7        = ins[31:25];
  c         = DECODER_CTRL_ILLEGAL;
  c.illegal = 1'b0;
  ok        = 1'b1;
  case (ins[6:0])
    OPC_LUI, OPC_AUIPC, OPC_JAL: begin
      c.alu_en    = 1'b1;
      c.rf_we     = 1'b1;
      c.alu_op    = (ins[6:0] == OPC_LUI) ? ALU_LUI : ALU_ADD;
      c.ctrl_xfer = (ins[6:0] == OPC_JAL) ? XFER_JAL : XFER_NONE;
    end
    OPC_JALR: begin
      c.alu_en    = 1'b1;
      c.rf_we     = 1'b1;
      c.rf_re     = 2'b01;
      c.ctrl_xfer = XFER_JALR;
      ok          = (f3 == 3'b000);
    end
    OPC_BRANCH: begin
      c.alu_en    = 1'b1;
      c.rf_re     = 2'b11;
      c.ctrl_xfer = XFER_BRANCH;
      c.alu_op    = (f3[2:1] == 2'b00) ? ALU_SUB : (f3[1] ? ALU_SLTU : ALU_SLT);
      ok          = (f3[2:1] != 2'b01);
    end
    OPC_LOAD: begin
      c.lsu_en       = 1'b1;
      c.rf_we        = 1'b1;
      c.rf_re        = 2'b01;
      c.lsu_type     = lsu_type_e'(f3[1:0]);
      c.lsu_sign_ext = !f3[2];
      ok             = f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
    end
    OPC_STORE: begin
      c.lsu_en   = 1'b1;
      c.lsu_we   = 1'b1;
      c.rf_re    = 2'b11;
      c.lsu_type = lsu_type_e'(f3[1:0]);
      ok         = f3 inside {3'd0, 3'd1, 3'd2};
    end
    OPC_OP_IMM: begin
      c.alu_en = 1'b1;
      c.rf_we  = 1'b1;
      c.rf_re  = 2'b01;
      c.alu_op = alu_sel(f3, (f3 == 3'd5) && f7[5]);
      if (f3 == 3'd1) begin
        ok = (f7 == 7'h00);                      // Shift amount only
      end else if (f3 == 3'd5) begin
        ok = (f7 == 7'h00) || (f7 == 7'h20);
      end
    end
    OPC_OP: begin
      c.rf_we = 1'b1;
      c.rf_re = 2'b11;
      if (f7 == 7'h01) begin                     // Multiply and divide
        ok       = (`DEC_M_EXT_EN != 0);
        c.mul_en = !f3[2];
        c.div_en = f3[2];
        if (f3[2]) begin
          c.div_op = div_op_e'(f3[1:0]);
        end else begin
          c.mul_op     = mul_op_e'(f3[1:0]);
          c.mul_signed = {f3[1:0] == 2'b01, (f3[1:0] == 2'b01) || (f3[1:0] == 2'b10)};
        end
      end else begin
        c.alu_en = 1'b1;
        c.alu_op = alu_sel(f3, f7[5]);
        ok       = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
      end
    end
    OPC_MISC: begin
      c.fencei = (f3 == 3'd1);
      ok       = (f3[2:1] == 2'b00);
    end
    OPC_SYSTEM: begin
      if (f3 == 3'd0) begin
        c.ecall = (ins == 32'h0000_0073);
        c.ebrk  = (ins == 32'h0010_0073);
        c.mret  = (ins == 32'h3020_0073);
        c.wfi   = (ins == 32'h1050_0073);
        ok      = c.ecall || c.ebrk || c.mret || c.wfi;
      end else begin
        c.csr_en   = 1'b1;
        c.rf_we    = 1'b1;
        c.rf_re[0] = !f3[2];
        c.csr_op   = (f3[1] && (ins[19:15] == 5'd0)) ? CSR_OP_READ : csr_op_e'(f3[1:0]);
        ok         = (f3[1:0] != 2'b00);
      end
    end
    default: ok = 1'b0;
  endcase
  if (!ok || ic) begin
    c = DECODER_CTRL_ILLEGAL;
  end
  if (fe) begin  // No side effects, op fields stay
    {c.alu_en, c.mul_en, c.div_en, c.lsu_en, c.lsu_we, c.rf_we, c.csr_en} = '0;
    {c.illegal, c.ecall, c.ebrk, c.mret, c.wfi, c.fencei} = '0;
    c.rf_re     = '0;
    c.csr_op    = CSR_OP_READ;
    c.ctrl_xfer = XFER_NONE;
  end
  return c;
endfunction

function automatic id_ex_pipe_t ref_decode(input if_id_pipe_t p);
  id_ex_pipe_t e;
  e.pc        = p.pc;
  e.rd        = p.instr[11:7];
  e.rs1       = p.instr[19:15];
  e.rs2       = p.instr[24:20];
  e.ctrl      = ref_ctrl(p.instr, p.illegal_c, p.fetch_err);
  e.fetch_err = p.fetch_err;
  return e;
endfunction

`endif

//--- tb/decode_tb.sv
// Decode slice testbench
`timescale 1ns/1ns
`default_nettype none

`include "dec_cfg.svh"

module decode_tb;
  import dec_pkg::*;

  `include "decode_ref.svh"

  localparam int N_RANDOM = 300;
  localparam int N_INSTR  = N_RANDOM + 100;  // Directed tests stay below 100

  logic        clk;
  logic        rst_n;
  logic        in_valid;
  logic        in_ready;
  if_id_pipe_t in_pipe;
  logic        out_valid;
  logic        out_ready;
  id_ex_pipe_t out_pipe;

  id_ex_pipe_t exp_q[$];     // Expected bundles, oldest first
  int          cyc;          // Rising edges so far
  int          in_cyc;       // Edge of the last input transfer
  int          out_cyc;      // Edge of the last output transfer
  int          n_checks;
  int          n_errors;
  int          chk_mark;
  int          err_mark;
  int          seed;
  int          bp_seed;
  logic        bp_on;        // Random back-pressure
  logic [31:0] pc;
  logic [6:0]  opc_tab [0:10] = '{OPC_LOAD, OPC_MISC, OPC_OP_IMM, OPC_AUIPC, OPC_STORE,
                                   OPC_OP, OPC_LUI, OPC_BRANCH, OPC_JALR, OPC_JAL,
                                   OPC_SYSTEM};

  decode_top DUT (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .in_pipe_i   (in_pipe),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .out_pipe_o  (out_pipe)
  );

  always #20 clk = ~clk;
  always @(posedge clk) cyc <= cyc + 1;

  // Sink side samples the mode on the edge
  always @(posedge clk) begin : bp_drive
    logic bp;
    bp = bp_on;
    #2;
    out_ready = bp ? (($random(bp_seed) & 3) != 0) : 1'b1;
  end

  task automatic report_mismatch(input string msg);
    n_errors++;
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
  endtask

  //////////////////////////////
  // Scoreboard
  //////////////////////////////

  // Sampled mid-cycle because handshakes complete on the next rising edge
  always @(negedge clk) begin : monitor
    id_ex_pipe_t head;
    if (rst_n) begin
      if (!out_valid) begin
        assert (in_ready) else report_mismatch("in_ready_o low with output stage empty");
      end
      if (out_valid && out_ready) begin
        out_cyc = cyc + 1;
        n_checks++;
        if (exp_q.size() == 0) begin
          n_errors++;
          $display("Output transfer at %0t ns with no instruction pending", $time);
        end else begin
          head = exp_q.pop_front();
          assert (out_pipe === head) else
            report_mismatch($sformatf("pc %h got %h expected %h", head.pc, out_pipe, head));
        end
      end
      if (in_valid && in_ready) begin
        exp_q.push_back(ref_decode(in_pipe));
        in_cyc = cyc + 1;
      end
    end
  end

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  function automatic logic [4:0] rreg();
    return 5'($random(seed));
  endfunction

  // Holds the input until it is taken
  task automatic send(input logic [31:0] ins, input logic ic, input logic fe);
    logic taken;
    in_valid = 1'b1;
    in_pipe  = '{pc: pc, instr: ins, illegal_c: ic, fetch_err: fe};
    taken    = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = in_ready;
      @(posedge clk);
      #2;
    end
    in_valid = 1'b0;
    pc       = pc + 32'd4;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic end_test(input string name);
    drain();
    idle(3);  // Room for a trailing duplicate to show up
    $display("%s: %0d checks, %0d errors", name, n_checks - chk_mark, n_errors - err_mark);
    chk_mark = n_checks;
    err_mark = n_errors;
  endtask

  initial begin
    #((N_INSTR + 20) * 4 * 40);
    $display("Watchdog expired, the pipeline stopped moving");
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    logic [31:0] ins;
    logic [3:0]  k;
    int          gap;
    clk      = 1'b0;
    rst_n    = 1'b0;
    in_valid = 1'b0;
    in_pipe  = '0;
    out_ready = 1'b1;
    bp_on    = 1'b0;
    pc       = 32'h0000_1000;
    cyc      = 0;
    in_cyc   = 0;
    out_cyc  = 0;
    n_checks = 0;
    n_errors = 0;
    chk_mark = 0;
    err_mark = 0;
    seed     = 5241;
    bp_seed  = seed + 1;
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // Idle state and then one instruction through an open pipe
    @(negedge clk);
    n_checks++;
    assert (!out_valid && in_ready) else report_mismatch("idle outputs wrong after reset");
    idle(1);
    send(enc_i(12'h123, 5'd1, 3'b000, 5'd2, OPC_OP_IMM), 1'b0, 1'b0);
    drain();
    n_checks++;
    assert (out_cyc - in_cyc == 2) else
      report_mismatch($sformatf("latency %0d cycles, expected 2", out_cyc - in_cyc));
    end_test("reset and latency");

    // RV32I groups back to back
    send(enc_u(20'hABCDE, rreg(), OPC_LUI), 1'b0, 1'b0);
    send(enc_u(20'h12345, rreg(), OPC_AUIPC), 1'b0, 1'b0);
    send(enc_u(20'h0F00F, rreg(), OPC_JAL), 1'b0, 1'b0);
    send(enc_i(12'h7F0, rreg(), 3'b000, rreg(), OPC_JALR), 1'b0, 1'b0);
    for (int f = 0; f < 8; f++) begin
      if (f != 2 && f != 3) begin
        send(enc_s(12'h8A4, rreg(), rreg(), 3'(f), OPC_BRANCH), 1'b0, 1'b0);
      end
      if (f != 3 && f < 6) begin                       // LB LH LW LBU LHU
        send(enc_i(12'h010, rreg(), 3'(f), rreg(), OPC_LOAD), 1'b0, 1'b0);
      end
      if (f < 3) begin
        send(enc_s(12'hFFC, rreg(), rreg(), 3'(f), OPC_STORE), 1'b0, 1'b0);
      end
      ins = (f == 1 || f == 5) ? {7'h00, rreg(), 20'h0} : 32'($random(seed)) << 20;
      send(enc_i(ins[31:20], rreg(), 3'(f), rreg(), OPC_OP_IMM), 1'b0, 1'b0);
      send(enc_r(7'h00, rreg(), rreg(), 3'(f), rreg(), OPC_OP), 1'b0, 1'b0);
      if (f != 0 && f != 4) begin                      // CSR register and immediate forms
        send(enc_i(12'h300, rreg(), 3'(f), rreg(), OPC_SYSTEM), 1'b0, 1'b0);
      end
    end
    send(enc_i({7'h20, 5'd7}, rreg(), 3'b101, rreg(), OPC_OP_IMM), 1'b0, 1'b0);  // SRAI
    send(enc_r(7'h20, rreg(), rreg(), 3'b000, rreg(), OPC_OP), 1'b0, 1'b0);      // SUB
    send(enc_r(7'h20, rreg(), rreg(), 3'b101, rreg(), OPC_OP), 1'b0, 1'b0);      // SRA
    send(enc_i(12'hC00, 5'd0, 3'b010, rreg(), OPC_SYSTEM), 1'b0, 1'b0);  // Set with x0 reads
    send(enc_i(12'h0FF, 5'd0, 3'b000, 5'd0, OPC_MISC), 1'b0, 1'b0);      // FENCE
    send(enc_i(12'h000, 5'd0, 3'b001, 5'd0, OPC_MISC), 1'b0, 1'b0);      // FENCE.I
    send(32'h0000_0073, 1'b0, 1'b0);
    send(32'h0010_0073, 1'b0, 1'b0);
    send(32'h3020_0073, 1'b0, 1'b0);
    send(32'h1050_0073, 1'b0, 1'b0);
    end_test("rv32i groups");

    for (int f = 0; f < 8; f++) begin
      send(enc_r(7'h01, rreg(), rreg(), 3'(f), rreg(), OPC_OP), 1'b0, 1'b0);
    end
    end_test("rv32m operations");

    // Reserved encodings and then the compressed error flag
    send(32'hFFFF_FFFF, 1'b0, 1'b0);
    send(enc_r(7'h02, rreg(), rreg(), 3'b000, rreg(), OPC_OP), 1'b0, 1'b0);
    send(enc_i(12'h000, rreg(), 3'b011, rreg(), OPC_LOAD), 1'b0, 1'b0);
    send(enc_s(12'h000, rreg(), rreg(), 3'b100, OPC_STORE), 1'b0, 1'b0);
    send(enc_s(12'h000, rreg(), rreg(), 3'b010, OPC_BRANCH), 1'b0, 1'b0);
    send(enc_i(12'h001, rreg(), 3'b001, rreg(), OPC_JALR), 1'b0, 1'b0);
    send(enc_i(12'h000, 5'd0, 3'b010, 5'd0, OPC_MISC), 1'b0, 1'b0);
    send(enc_i(12'h400, rreg(), 3'b001, rreg(), OPC_OP_IMM), 1'b0, 1'b0);
    send(32'h0020_0073, 1'b0, 1'b0);
    send(enc_i(12'h300, rreg(), 3'b100, rreg(), OPC_SYSTEM), 1'b0, 1'b0);
    send(enc_r(7'h00, rreg(), rreg(), 3'b000, rreg(), OPC_OP), 1'b1, 1'b0);
    send(enc_r(7'h01, rreg(), rreg(), 3'b000, rreg(), OPC_OP), 1'b1, 1'b0);
    send(32'hFFFF_FFFF, 1'b1, 1'b0);
    end_test("illegal encodings");

    send(enc_s(12'h010, rreg(), rreg(), 3'b010, OPC_STORE), 1'b0, 1'b1);
    send(32'hFFFF_FFFF, 1'b0, 1'b1);
    send(enc_i(12'h300, rreg(), 3'b001, rreg(), OPC_SYSTEM), 1'b0, 1'b1);
    send(enc_r(7'h01, rreg(), rreg(), 3'b100, rreg(), OPC_OP), 1'b0, 1'b1);
    send(32'h0000_0073, 1'b0, 1'b1);
    send(enc_u(20'h00100, rreg(), OPC_JAL), 1'b0, 1'b1);
    send(enc_r(7'h00, rreg(), rreg(), 3'b000, rreg(), OPC_OP), 1'b1, 1'b1);
    end_test("fetch error");

    // Mixed stream under back-pressure
    bp_on = 1'b1;
    for (int n = 0; n < N_RANDOM; n++) begin
      ins = $random(seed);
      if (ins[0]) begin
        k         = 4'($unsigned($random(seed)) % 11);
        ins[6:0]  = opc_tab[k];
        if (ins[6:0] == OPC_OP) begin
          ins[31:25] = ins[25] ? 7'h01 : {1'b0, ins[30], 5'b00000};
        end
      end
      send(ins, (($random(seed) & 15) == 0), (($random(seed) & 15) == 0));
      gap = $unsigned($random(seed)) % 3;
      idle(gap);
    end
    bp_on = 1'b0;  // Open sink so the tail drains at full rate
    end_test("random stream");

    $display("Total: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src/decode_top.sv
// Decode slice top level
`timescale 1ns/1ns
`default_nettype none

module decode_top (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  dec_pkg::if_id_pipe_t in_pipe_i,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output dec_pkg::id_ex_pipe_t out_pipe_o
);
  import dec_pkg::*;

  logic          if_id_valid;  // IF/ID holds an instruction
  logic          if_id_ready;  // ID/EX can take it
  if_id_pipe_t   if_id_pipe;
  decoder_ctrl_t dec_ctrl;     // Combinational decode of if_id_pipe

  if_id_stage if_id_stage_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_pipe_i   (in_pipe_i),
    .out_valid_o (if_id_valid),
    .out_ready_i (if_id_ready),
    .out_pipe_o  (if_id_pipe)
  );

  decoder decoder_i (
    .if_id_pipe_i (if_id_pipe),
    .ctrl_o       (dec_ctrl)
  );

  id_ex_stage id_ex_stage_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .in_valid_i   (if_id_valid),
    .in_ready_o   (if_id_ready),
    .if_id_pipe_i (if_id_pipe),
    .ctrl_i       (dec_ctrl),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .out_pipe_o   (out_pipe_o)
  );

endmodule

`default_nettype wire

//--- src/id_ex_stage.sv
// ID/EX pipeline register
`timescale 1ns/1ns
`default_nettype none

module id_ex_stage (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // From IF/ID and decoder
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  input  dec_pkg::if_id_pipe_t   if_id_pipe_i,
  input  dec_pkg::decoder_ctrl_t ctrl_i,
  // Towards execute
  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  output dec_pkg::id_ex_pipe_t   out_pipe_o
);
  import dec_pkg::*;

  id_ex_pipe_t pipe_d;  // Bundle to capture

  // Register fields sit at fixed positions in every format
  always_comb begin
    pipe_d.pc        = if_id_pipe_i.pc;
    pipe_d.rd        = if_id_pipe_i.instr[11:7];
    pipe_d.rs1       = if_id_pipe_i.instr[19:15];
    pipe_d.rs2       = if_id_pipe_i.instr[24:20];
    pipe_d.ctrl      = ctrl_i;
    pipe_d.fetch_err = if_id_pipe_i.fetch_err;
  end

  assign in_ready_o = !out_valid_o || out_ready_i;  // Empty or draining

  //////////////////////////////
  // Valid and payload
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_valid_o <= 1'b0;
    end else if (in_ready_o) begin
      out_valid_o <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      out_pipe_o <= pipe_d;  // Held under back-pressure
    end
  end

endmodule

`default_nettype wire

//--- src/decoder.sv
// Central instruction decoder
`timescale 1ns/1ns
`default_nettype none

`include "dec_cfg.svh"

module decoder (
  input  dec_pkg::if_id_pipe_t   if_id_pipe_i,
  output dec_pkg::decoder_ctrl_t ctrl_o
);
  import dec_pkg::*;

  decoder_ctrl_t i_ctrl;    // RV32I result
  decoder_ctrl_t m_ctrl;    // RV32M result
  decoder_ctrl_t mux_ctrl;  // Selected before fetch error handling

  i_decoder i_decoder_i (
    .instr_i (if_id_pipe_i.instr),
    .ctrl_o  (i_ctrl)
  );

  generate
    if (`DEC_M_EXT_EN) begin : gen_m_dec
      m_decoder m_decoder_i (
        .instr_i (if_id_pipe_i.instr),
        .ctrl_o  (m_ctrl)
      );
    end else begin : gen_no_m_dec
      assign m_ctrl = DECODER_CTRL_ILLEGAL;  // Never matches
    end
  endgenerate

  //////////////////////////////
  // Sub-decoder selection
  //////////////////////////////

  always_comb begin
    if (if_id_pipe_i.illegal_c) begin
      mux_ctrl = DECODER_CTRL_ILLEGAL;  // Bad compressed encoding wins
    end else if (!m_ctrl.illegal) begin
      mux_ctrl = m_ctrl;
    end else if (!i_ctrl.illegal) begin
      mux_ctrl = i_ctrl;
    end else begin
      mux_ctrl = DECODER_CTRL_ILLEGAL;
    end
  end

  //////////////////////////////
  // Fetch error suppression
  //////////////////////////////

  // Instruction word is garbage, only the error travels on
  always_comb begin
    ctrl_o = mux_ctrl;
    if (if_id_pipe_i.fetch_err) begin
      ctrl_o.alu_en    = 1'b0;
      ctrl_o.mul_en    = 1'b0;
      ctrl_o.div_en    = 1'b0;
      ctrl_o.lsu_en    = 1'b0;
      ctrl_o.lsu_we    = 1'b0;
      ctrl_o.rf_we     = 1'b0;
      ctrl_o.rf_re     = '0;
      ctrl_o.csr_en    = 1'b0;
      ctrl_o.csr_op    = CSR_OP_READ;
      ctrl_o.ctrl_xfer = XFER_NONE;
      ctrl_o.illegal   = 1'b0;  // Fetch error has the higher priority
      ctrl_o.ecall     = 1'b0;
      ctrl_o.ebrk      = 1'b0;
      ctrl_o.mret      = 1'b0;
      ctrl_o.wfi       = 1'b0;
      ctrl_o.fencei    = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- src/m_decoder.sv
// RV32M multiply and divide decoder
`timescale 1ns/1ns
`default_nettype none

module m_decoder (
  input  logic [31:0]            instr_i,
  output dec_pkg::decoder_ctrl_t ctrl_o
);
  import dec_pkg::*;

  logic match;  // OP opcode with funct7 0000001

  assign match = (instr_i[6:0] == OPC_OP) && (instr_i[31:25] == 7'b0000001);

  always_comb begin
    ctrl_o = DECODER_CTRL_ILLEGAL;
    if (match) begin
      ctrl_o.illegal  = 1'b0;
      ctrl_o.rf_we    = 1'b1;
      ctrl_o.rf_re[0] = 1'b1;
      ctrl_o.rf_re[1] = 1'b1;
      if (!instr_i[14]) begin
        // funct3 0xx, multiplier
        ctrl_o.mul_en = 1'b1;
        ctrl_o.mul_op = mul_op_e'(instr_i[13:12]);
        case (instr_i[13:12])
          2'b01:   ctrl_o.mul_signed = 2'b11;  // MULH
          2'b10:   ctrl_o.mul_signed = 2'b01;  // MULHSU, rs1 only
          default: ctrl_o.mul_signed = 2'b00;  // MUL low half, MULHU
        endcase
      end else begin
        ctrl_o.div_en = 1'b1;                       // funct3 1xx, divider
        ctrl_o.div_op = div_op_e'(instr_i[13:12]);  // DIV, DIVU, REM, REMU
      end
    end
  end

endmodule

`default_nettype wire

//--- src/i_decoder.sv
// RV32I base decoder
`timescale 1ns/1ns
`default_nettype none

module i_decoder (
  input  logic [31:0]            instr_i,
  output dec_pkg::decoder_ctrl_t ctrl_o
);
  import dec_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       insn_illegal;  // Any field combination not in RV32I

  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  always_comb begin
    ctrl_o         = DECODER_CTRL_ILLEGAL;  // Every enable off
    ctrl_o.illegal = 1'b0;
    insn_illegal   = 1'b0;

    case (opcode)
      OPC_LUI: begin
        ctrl_o.alu_en = 1'b1;
        ctrl_o.alu_op = ALU_LUI;  // Upper immediate passes through
        ctrl_o.rf_we  = 1'b1;
      end
      OPC_AUIPC: begin
        ctrl_o.alu_en = 1'b1;     // PC + upper immediate
        ctrl_o.rf_we  = 1'b1;
      end
      OPC_JAL: begin
        ctrl_o.alu_en    = 1'b1;  // Link address
        ctrl_o.rf_we     = 1'b1;
        ctrl_o.ctrl_xfer = XFER_JAL;
      end
      OPC_JALR: begin
        ctrl_o.alu_en    = 1'b1;
        ctrl_o.rf_we     = 1'b1;
        ctrl_o.rf_re[0]  = 1'b1;
        ctrl_o.ctrl_xfer = XFER_JALR;
        insn_illegal     = (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        ctrl_o.alu_en    = 1'b1;  // Comparison
        ctrl_o.rf_re[0]  = 1'b1;
        ctrl_o.rf_re[1]  = 1'b1;
        ctrl_o.ctrl_xfer = XFER_BRANCH;
        case (funct3)
          3'b000, 3'b001: ctrl_o.alu_op = ALU_SUB;   // BEQ, BNE
          3'b100, 3'b101: ctrl_o.alu_op = ALU_SLT;   // BLT, BGE
          3'b110, 3'b111: ctrl_o.alu_op = ALU_SLTU;  // BLTU, BGEU
          default:        insn_illegal  = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        ctrl_o.lsu_en       = 1'b1;
        ctrl_o.rf_we        = 1'b1;
        ctrl_o.rf_re[0]     = 1'b1;
        ctrl_o.lsu_type     = lsu_type_e'(funct3[1:0]);
        ctrl_o.lsu_sign_ext = ~funct3[2];                // LBU, LHU zero extend
        insn_illegal        = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
      end
      OPC_STORE: begin
        ctrl_o.lsu_en   = 1'b1;
        ctrl_o.lsu_we   = 1'b1;
        ctrl_o.rf_re[0] = 1'b1;  // Base address
        ctrl_o.rf_re[1] = 1'b1;  // Store data
        ctrl_o.lsu_type = lsu_type_e'(funct3[1:0]);
        insn_illegal    = funct3[2] || (funct3[1:0] == 2'b11);
      end
      OPC_OP_IMM: begin
        ctrl_o.alu_en   = 1'b1;
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.rf_re[0] = 1'b1;
        case (funct3)
          3'b000: ctrl_o.alu_op = ALU_ADD;
          3'b010: ctrl_o.alu_op = ALU_SLT;
          3'b011: ctrl_o.alu_op = ALU_SLTU;
          3'b100: ctrl_o.alu_op = ALU_XOR;
          3'b110: ctrl_o.alu_op = ALU_OR;
          3'b111: ctrl_o.alu_op = ALU_AND;
          3'b001: begin
            ctrl_o.alu_op = ALU_SLL;
            insn_illegal  = (funct7 != 7'b0000000);
          end
          default: begin  // SRLI or SRAI, bit 30 selects arithmetic
            ctrl_o.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
            insn_illegal  = ({funct7[6], funct7[4:0]} != 6'b000000);
          end
        endcase
      end
      OPC_OP: begin
        ctrl_o.alu_en   = 1'b1;
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.rf_re[0] = 1'b1;
        ctrl_o.rf_re[1] = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: ctrl_o.alu_op = ALU_ADD;
          {7'b0100000, 3'b000}: ctrl_o.alu_op = ALU_SUB;
          {7'b0000000, 3'b001}: ctrl_o.alu_op = ALU_SLL;
          {7'b0000000, 3'b010}: ctrl_o.alu_op = ALU_SLT;
          {7'b0000000, 3'b011}: ctrl_o.alu_op = ALU_SLTU;
          {7'b0000000, 3'b100}: ctrl_o.alu_op = ALU_XOR;
          {7'b0000000, 3'b101}: ctrl_o.alu_op = ALU_SRL;
          {7'b0100000, 3'b101}: ctrl_o.alu_op = ALU_SRA;
          {7'b0000000, 3'b110}: ctrl_o.alu_op = ALU_OR;
          {7'b0000000, 3'b111}: ctrl_o.alu_op = ALU_AND;
          default:              insn_illegal  = 1'b1;  // RV32M lands here too
        endcase
      end
      OPC_MISC: begin
        case (funct3)
          3'b000:  ctrl_o.fencei = 1'b0;  // FENCE, nothing to order in this core
          3'b001:  ctrl_o.fencei = 1'b1;
          default: insn_illegal  = 1'b1;
        endcase
      end
      OPC_SYSTEM: begin
        if (funct3 == 3'b000) begin
          case (instr_i)  // Exact encodings only
            32'h0000_0073: ctrl_o.ecall = 1'b1;
            32'h0010_0073: ctrl_o.ebrk  = 1'b1;
            32'h3020_0073: ctrl_o.mret  = 1'b1;
            32'h1050_0073: ctrl_o.wfi   = 1'b1;
            default:       insn_illegal = 1'b1;
          endcase
        end else begin
          ctrl_o.csr_en   = 1'b1;
          ctrl_o.rf_we    = 1'b1;
          ctrl_o.rf_re[0] = ~funct3[2];  // Immediate forms read no register
          case (funct3[1:0])
            2'b01:   ctrl_o.csr_op = CSR_OP_WRITE;
            2'b10:   ctrl_o.csr_op = CSR_OP_SET;
            2'b11:   ctrl_o.csr_op = CSR_OP_CLEAR;
            default: insn_illegal  = 1'b1;  // funct3 100
          endcase
          // Set or clear with a zero source field leaves the CSR untouched
          if (funct3[1] && (instr_i[19:15] == 5'd0)) begin
            ctrl_o.csr_op = CSR_OP_READ;
          end
        end
      end
      default: insn_illegal = 1'b1;
    endcase

    if (insn_illegal) begin
      ctrl_o = DECODER_CTRL_ILLEGAL;
    end
  end

endmodule

`default_nettype wire

//--- src/if_id_stage.sv
// IF/ID pipeline register
`timescale 1ns/1ns
`default_nettype none

module if_id_stage (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // From fetch
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  dec_pkg::if_id_pipe_t in_pipe_i,
  // Towards decode and ID/EX
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output dec_pkg::if_id_pipe_t out_pipe_o
);

  logic load;  // Input transfer this cycle

  // Free when empty or when the held entry moves on now
  assign in_ready_o = !out_valid_o || out_ready_i;
  assign load       = in_valid_i && in_ready_o;

  //////////////////////////////
  // Valid bit
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_valid_o <= 1'b0;
    end else if (in_ready_o) begin
      out_valid_o <= in_valid_i;  // Refill or drain
    end
  end

  //////////////////////////////
  // Payload
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (load) begin
      out_pipe_o <= in_pipe_i;  // Held until downstream takes it
    end
  end

endmodule

`default_nettype wire

//--- src/dec_pkg.sv
// Decode slice types
`default_nettype none

`include "dec_cfg.svh"

package dec_pkg;

  //////////////////////////////
  // Encodings
  //////////////////////////////

  // Major opcodes, bits [6:0] of a 32-bit instruction
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_MISC   = 7'b0001111,  // FENCE, FENCE.I
    OPC_OP_IMM = 7'b0010011,
    OPC_AUIPC  = 7'b0010111,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,  // Shared by RV32I and RV32M
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI
  } alu_op_e;

  // Values follow funct3 of the M encodings
  typedef enum logic [1:0] {MUL_MUL, MUL_MULH, MUL_MULHSU, MUL_MULHU} mul_op_e;
  typedef enum logic [1:0] {DIV_DIV, DIV_DIVU, DIV_REM, DIV_REMU} div_op_e;

  typedef enum logic [1:0] {LSU_BYTE, LSU_HALF, LSU_WORD} lsu_type_e;  // funct3[1:0]

  typedef enum logic [1:0] {CSR_OP_READ, CSR_OP_WRITE, CSR_OP_SET, CSR_OP_CLEAR} csr_op_e;

  typedef enum logic [1:0] {XFER_NONE, XFER_JAL, XFER_JALR, XFER_BRANCH} ctrl_xfer_e;

  //////////////////////////////
  // Pipeline bundles
  //////////////////////////////

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
    logic        illegal_c;  // Compressed expansion failed
    logic        fetch_err;  // Bus error on fetch
  } if_id_pipe_t;

  typedef struct packed {
    logic                        alu_en;
    alu_op_e                     alu_op;
    logic                        mul_en;
    mul_op_e                     mul_op;
    logic [1:0]                  mul_signed;  // Bit 0 rs1 signed, bit 1 rs2 signed
    logic                        div_en;
    div_op_e                     div_op;
    logic                        lsu_en;
    logic                        lsu_we;
    lsu_type_e                   lsu_type;
    logic                        lsu_sign_ext;
    logic                        rf_we;
    logic [`DEC_RF_RD_PORTS-1:0] rf_re;       // Bit 0 rs1, bit 1 rs2
    logic                        csr_en;
    csr_op_e                     csr_op;
    ctrl_xfer_e                  ctrl_xfer;
    logic                        illegal;
    logic                        ecall;
    logic                        ebrk;
    logic                        mret;
    logic                        wfi;
    logic                        fencei;
  } decoder_ctrl_t;

  // Result of a sub-decoder without a match
  localparam decoder_ctrl_t DECODER_CTRL_ILLEGAL = '{
    alu_en:       1'b0,
    alu_op:       ALU_ADD,
    mul_en:       1'b0,
    mul_op:       MUL_MUL,
    mul_signed:   2'b00,
    div_en:       1'b0,
    div_op:       DIV_DIV,
    lsu_en:       1'b0,
    lsu_we:       1'b0,
    lsu_type:     LSU_WORD,
    lsu_sign_ext: 1'b0,
    rf_we:        1'b0,
    rf_re:        '0,
    csr_en:       1'b0,
    csr_op:       CSR_OP_READ,
    ctrl_xfer:    XFER_NONE,
    illegal:      1'b1,
    ecall:        1'b0,
    ebrk:         1'b0,
    mret:         1'b0,
    wfi:          1'b0,
    fencei:       1'b0
  };

  typedef struct packed {
    logic [31:0]   pc;
    logic [4:0]    rd;
    logic [4:0]    rs1;
    logic [4:0]    rs2;
    decoder_ctrl_t ctrl;
    logic          fetch_err;
  } id_ex_pipe_t;

endpackage

`default_nettype wire

//--- src/dec_cfg.svh
// Decode slice build options
`ifndef DEC_CFG_SVH
`define DEC_CFG_SVH

// RV32M support, 0 leaves multiply and divide encodings illegal
`define DEC_M_EXT_EN 1

// Register file read ports, one read enable bit per port
`define DEC_RF_RD_PORTS 2

`endif
